// ==== cbuf_pkg.sv ====
package cbuf_pkg;

	// buffer geometry
	localparam int ATOMIC_C = 4; // channel parallelism
	localparam int WORD_BYTES = ATOMIC_C * 2; // two bytes per channel
	localparam int WORD_BITS = WORD_BYTES * 8;
	localparam int BANK_N = 8;
	localparam int BANK_DEPTH = 64; // words per bank
	localparam int BANK_IDX_W = $clog2(BANK_N);
	localparam int ROW_W = $clog2(BANK_DEPTH);

	// 0 .. BANK_N banks handed to the feature-map region
	typedef logic [3:0] bank_cnt_t;

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [WORD_BYTES-1:0] mask_t;

	// one request from a port access unit to the bank array
	typedef struct packed {
		logic en;
		mask_t wmask; // all zero means read
		logic [BANK_IDX_W-1:0] bank; // physical bank
		logic [ROW_W-1:0] row;
		word_t wdata;
	} bank_req_t;

endpackage

// ==== icb_pkg.sv ====
package icb_pkg;

	typedef enum logic {
		ICB_WRITE = 1'b0,
		ICB_READ = 1'b1
	} icb_op_e;

	// command channel payload
	typedef struct packed {
		logic [31:0] addr; // byte address, word aligned
		icb_op_e op;
		cbuf_pkg::word_t wdata;
		cbuf_pkg::mask_t wmask; // byte enables for writes
	} icb_cmd_t;

	// response channel payload
	typedef struct packed {
		cbuf_pkg::word_t rdata; // zero on writes and errors
		logic err; // logical address out of region
	} icb_rsp_t;

endpackage

// ==== icb_reg_slice.sv ====
`timescale 1ns/10ps

module icb_reg_slice #(
	parameter type T = logic
) (
	input logic clk,
	input logic rst_n,

	input T in_data,
	input logic in_valid,
	output logic in_ready,

	output T out_data,
	output logic out_valid,
	input logic out_ready
);

	T main_q; // entry presented downstream
	T spare_q; // skid entry caught under back-pressure
	logic main_vld;
	logic spare_vld;
	logic main_vld_nxt;
	logic spare_vld_nxt;
	logic in_fire;
	logic main_free;

	assign in_fire = in_valid & in_ready;
	// main entry leaves or is empty this cycle
	assign main_free = ~main_vld | out_ready;

	always_comb begin
		if (main_free) begin
			main_vld_nxt = spare_vld | in_fire; // spare first, keeps order
			spare_vld_nxt = 1'b0;
		end else begin
			main_vld_nxt = 1'b1;
			spare_vld_nxt = spare_vld | in_fire;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			main_vld <= 1'b0;
			spare_vld <= 1'b0;
			in_ready <= 1'b1;
		end else begin
			main_vld <= main_vld_nxt;
			spare_vld <= spare_vld_nxt;
			in_ready <= ~spare_vld_nxt; // registered ready
		end
	end

	always_ff @(posedge clk) begin
		if (main_free) begin
			if (spare_vld)
				main_q <= spare_q;
			else if (in_fire)
				main_q <= in_data;
		end
		// main still stalled, park the new item
		if (!main_free && in_fire)
			spare_q <= in_data;
	end

	assign out_data = main_q;
	assign out_valid = main_vld;

endmodule

// ==== cbuf_port_access.sv ====
`timescale 1ns/10ps

module cbuf_port_access #(
	parameter bit KERNEL_REGION = 1'b0 // 0 fm mapping, 1 kb mapping
) (
	input logic clk,
	input logic rst_n,
	input cbuf_pkg::bank_cnt_t fmbufbankn,

	input icb_pkg::icb_cmd_t cmd,
	input logic cmd_valid,
	output logic cmd_ready,

	output icb_pkg::icb_rsp_t rsp,
	output logic rsp_valid,
	input logic rsp_ready,

	output cbuf_pkg::bank_req_t bank_req,
	input cbuf_pkg::word_t bank_rdata
);

	typedef enum logic [1:0] {
		RSP_IDLE,
		RSP_FRESH, // bank data valid this cycle
		RSP_HELD // bank data sits in held_rdata
	} rsp_state_e;

	rsp_state_e rsp_state;
	logic [31:0] word_idx;
	logic [31:0] lbank; // logical bank inside the region
	logic [cbuf_pkg::ROW_W-1:0] row;
	logic [cbuf_pkg::BANK_IDX_W-1:0] pbank;
	logic in_bound;
	logic cmd_fire;
	logic pend_read;
	logic pend_err;
	cbuf_pkg::word_t held_rdata;

	// aligned byte address to bank and row
	always_comb begin
		word_idx = cmd.addr / cbuf_pkg::WORD_BYTES; // low bits dropped
		lbank = word_idx / cbuf_pkg::BANK_DEPTH;
		row = cbuf_pkg::ROW_W'(word_idx % cbuf_pkg::BANK_DEPTH);
		if (KERNEL_REGION) begin
			// kernel banks sit above the feature-map banks
			in_bound = lbank < (32'(cbuf_pkg::BANK_N) - 32'(fmbufbankn));
			pbank = cbuf_pkg::BANK_IDX_W'(lbank + 32'(fmbufbankn));
		end else begin
			in_bound = lbank < 32'(fmbufbankn);
			pbank = cbuf_pkg::BANK_IDX_W'(lbank);
		end
	end

	// stall while a response waits downstream
	assign cmd_ready = ~rsp_valid | rsp_ready;
	assign cmd_fire = cmd_valid & cmd_ready;

	always_comb begin
		bank_req.en = cmd_fire & in_bound; // no bank touched when out of region
		bank_req.wmask = (cmd.op == icb_pkg::ICB_WRITE) ? cmd.wmask : '0;
		bank_req.bank = pbank;
		bank_req.row = row;
		bank_req.wdata = cmd.wdata;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rsp_state <= RSP_IDLE;
		end else if (cmd_fire) begin
			rsp_state <= RSP_FRESH;
		end else if (rsp_valid && rsp_ready) begin
			rsp_state <= RSP_IDLE;
		end else if (rsp_state == RSP_FRESH) begin
			rsp_state <= RSP_HELD; // not taken yet
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_fire) begin
			pend_read <= (cmd.op == icb_pkg::ICB_READ);
			pend_err <= ~in_bound;
		end
		if (rsp_state == RSP_FRESH)
			held_rdata <= bank_rdata;
	end

	assign rsp_valid = (rsp_state != RSP_IDLE);

	always_comb begin
		rsp.err = pend_err;
		if (pend_read && !pend_err)
			rsp.rdata = (rsp_state == RSP_FRESH) ? bank_rdata : held_rdata;
		else
			rsp.rdata = '0;
	end

endmodule

// ==== cbuf_bank_array.sv ====
`timescale 1ns/10ps

module cbuf_bank_array (
	input logic clk,

	input cbuf_pkg::bank_req_t fm_req,
	input cbuf_pkg::bank_req_t kb_req,

	output cbuf_pkg::word_t fm_rdata,
	output cbuf_pkg::word_t kb_rdata
);

	cbuf_pkg::word_t bank_dout [cbuf_pkg::BANK_N];
	logic [cbuf_pkg::BANK_IDX_W-1:0] fm_sel; // bank fm read last
	logic [cbuf_pkg::BANK_IDX_W-1:0] kb_sel;

	for (genvar b = 0; b < cbuf_pkg::BANK_N; b++) begin : g_bank
		cbuf_pkg::word_t mem [cbuf_pkg::BANK_DEPTH];
		cbuf_pkg::word_t dout;
		cbuf_pkg::bank_req_t req;

		// steer the request aimed at this bank
		always_comb begin
			if (fm_req.en && fm_req.bank == cbuf_pkg::BANK_IDX_W'(b))
				req = fm_req; // fm wins a collision
			else if (kb_req.en && kb_req.bank == cbuf_pkg::BANK_IDX_W'(b))
				req = kb_req;
			else
				req = '0;
		end

		// single port, byte masked write or registered read
		always_ff @(posedge clk) begin
			if (req.en) begin
				if (req.wmask == '0)
					dout <= mem[req.row];
				for (int i = 0; i < cbuf_pkg::WORD_BYTES; i++) begin
					if (req.wmask[i])
						mem[req.row][i*8 +: 8] <= req.wdata[i*8 +: 8];
				end
			end
		end

		assign bank_dout[b] = dout;
	end

	// remember which bank each port hit
	always_ff @(posedge clk) begin
		if (fm_req.en)
			fm_sel <= fm_req.bank;
		if (kb_req.en)
			kb_sel <= kb_req.bank;
	end

	assign fm_rdata = bank_dout[fm_sel];
	assign kb_rdata = bank_dout[kb_sel];

endmodule

// ==== conv_buffer.sv ====
`timescale 1ns/10ps

module conv_buffer (
	input logic aclk,
	input logic rst_n,
	input cbuf_pkg::bank_cnt_t fmbufbankn, // banks owned by the fm region

	// feature-map port
	input icb_pkg::icb_cmd_t fm_cmd,
	input logic fm_cmd_valid,
	output logic fm_cmd_ready,
	output icb_pkg::icb_rsp_t fm_rsp,
	output logic fm_rsp_valid,
	input logic fm_rsp_ready,

	// kernel port
	input icb_pkg::icb_cmd_t kb_cmd,
	input logic kb_cmd_valid,
	output logic kb_cmd_ready,
	output icb_pkg::icb_rsp_t kb_rsp,
	output logic kb_rsp_valid,
	input logic kb_rsp_ready
);

	icb_pkg::icb_cmd_t fm_acc_cmd;
	logic fm_acc_cmd_valid;
	logic fm_acc_cmd_ready;
	icb_pkg::icb_rsp_t fm_acc_rsp;
	logic fm_acc_rsp_valid;
	logic fm_acc_rsp_ready;
	cbuf_pkg::bank_req_t fm_bank_req;
	cbuf_pkg::word_t fm_bank_rdata;

	icb_pkg::icb_cmd_t kb_acc_cmd;
	logic kb_acc_cmd_valid;
	logic kb_acc_cmd_ready;
	icb_pkg::icb_rsp_t kb_acc_rsp;
	logic kb_acc_rsp_valid;
	logic kb_acc_rsp_ready;
	cbuf_pkg::bank_req_t kb_bank_req;
	cbuf_pkg::word_t kb_bank_rdata;

	icb_reg_slice #(.T(icb_pkg::icb_cmd_t)) u_fm_cmd_slice (
		.clk(aclk), .rst_n(rst_n),
		.in_data(fm_cmd), .in_valid(fm_cmd_valid), .in_ready(fm_cmd_ready),
		.out_data(fm_acc_cmd), .out_valid(fm_acc_cmd_valid), .out_ready(fm_acc_cmd_ready)
	);

	icb_reg_slice #(.T(icb_pkg::icb_rsp_t)) u_fm_rsp_slice (
		.clk(aclk), .rst_n(rst_n),
		.in_data(fm_acc_rsp), .in_valid(fm_acc_rsp_valid), .in_ready(fm_acc_rsp_ready),
		.out_data(fm_rsp), .out_valid(fm_rsp_valid), .out_ready(fm_rsp_ready)
	);

	icb_reg_slice #(.T(icb_pkg::icb_cmd_t)) u_kb_cmd_slice (
		.clk(aclk), .rst_n(rst_n),
		.in_data(kb_cmd), .in_valid(kb_cmd_valid), .in_ready(kb_cmd_ready),
		.out_data(kb_acc_cmd), .out_valid(kb_acc_cmd_valid), .out_ready(kb_acc_cmd_ready)
	);

	icb_reg_slice #(.T(icb_pkg::icb_rsp_t)) u_kb_rsp_slice (
		.clk(aclk), .rst_n(rst_n),
		.in_data(kb_acc_rsp), .in_valid(kb_acc_rsp_valid), .in_ready(kb_acc_rsp_ready),
		.out_data(kb_rsp), .out_valid(kb_rsp_valid), .out_ready(kb_rsp_ready)
	);

	cbuf_port_access #(.KERNEL_REGION(1'b0)) u_fm_access (
		.clk(aclk), .rst_n(rst_n), .fmbufbankn(fmbufbankn),
		.cmd(fm_acc_cmd), .cmd_valid(fm_acc_cmd_valid), .cmd_ready(fm_acc_cmd_ready),
		.rsp(fm_acc_rsp), .rsp_valid(fm_acc_rsp_valid), .rsp_ready(fm_acc_rsp_ready),
		.bank_req(fm_bank_req), .bank_rdata(fm_bank_rdata)
	);

	cbuf_port_access #(.KERNEL_REGION(1'b1)) u_kb_access (
		.clk(aclk), .rst_n(rst_n), .fmbufbankn(fmbufbankn),
		.cmd(kb_acc_cmd), .cmd_valid(kb_acc_cmd_valid), .cmd_ready(kb_acc_cmd_ready),
		.rsp(kb_acc_rsp), .rsp_valid(kb_acc_rsp_valid), .rsp_ready(kb_acc_rsp_ready),
		.bank_req(kb_bank_req), .bank_rdata(kb_bank_rdata)
	);

	// shared pool, split by fmbufbankn
	cbuf_bank_array u_bank_array (
		.clk(aclk),
		.fm_req(fm_bank_req), .kb_req(kb_bank_req),
		.fm_rdata(fm_bank_rdata), .kb_rdata(kb_bank_rdata)
	);

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 5,
	parameter int DRIVE_DLY = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DLY);
		rst_n = 1'b1; // released like any other input
	end

endmodule

// ==== tb_conv_buffer.sv ====
`timescale 1ns/10ps

module tb_conv_buffer;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY = 10;
	localparam int SEED = 97;
	localparam int FILL_N = cbuf_pkg::BANK_N * cbuf_pkg::BANK_DEPTH;
	localparam int PAIR_N = 12; // addresses shared by tests 2 and 3
	localparam int SPLIT_N = 4;
	localparam int RAND_N = 300; // random commands per port
	localparam int CMD_TOTAL = FILL_N + 1 + 5 * PAIR_N + 5 + 2 * SPLIT_N + 2 * RAND_N;
	localparam int WATCHDOG_CYCLES = CMD_TOTAL * 20;
	localparam int CMD_RATE = 70; // percent of cycles with cmd_valid under back-pressure
	localparam int RSP_RATE = 60;

	logic aclk;
	logic rst_n;
	cbuf_pkg::bank_cnt_t fmbufbankn;
	icb_pkg::icb_cmd_t fm_cmd;
	logic fm_cmd_valid;
	logic fm_cmd_ready;
	icb_pkg::icb_rsp_t fm_rsp;
	logic fm_rsp_valid;
	logic fm_rsp_ready;
	icb_pkg::icb_cmd_t kb_cmd;
	logic kb_cmd_valid;
	logic kb_cmd_ready;
	icb_pkg::icb_rsp_t kb_rsp;
	logic kb_rsp_valid;
	logic kb_rsp_ready;

	icb_pkg::icb_cmd_t fm_q [$]; // commands waiting to be driven
	icb_pkg::icb_cmd_t kb_q [$];
	icb_pkg::icb_rsp_t fm_exp [$]; // responses owed, in command order
	icb_pkg::icb_rsp_t kb_exp [$];
	logic [7:0] ref_bytes [FILL_N * cbuf_pkg::WORD_BYTES];
	icb_pkg::icb_rsp_t model_rsp;

	bit bp_mode;
	bit fm_fired;
	bit kb_fired;
	int cycle = 0;
	int fm_cmd_cyc;
	int fm_rsp_cyc;
	int err_cnt = 0;
	int check_cnt = 0;
	int test_cnt = 0;
	int test_err0 = 0;
	int pair_lb [PAIR_N];
	int pair_row [PAIR_N];

	tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5), .DRIVE_DLY(DRIVE_DLY)) u_clk_gen (
		.clk(aclk), .rst_n(rst_n)
	);

	conv_buffer DUT (
		.aclk(aclk), .rst_n(rst_n), .fmbufbankn(fmbufbankn),
		.fm_cmd(fm_cmd), .fm_cmd_valid(fm_cmd_valid), .fm_cmd_ready(fm_cmd_ready),
		.fm_rsp(fm_rsp), .fm_rsp_valid(fm_rsp_valid), .fm_rsp_ready(fm_rsp_ready),
		.kb_cmd(kb_cmd), .kb_cmd_valid(kb_cmd_valid), .kb_cmd_ready(kb_cmd_ready),
		.kb_rsp(kb_rsp), .kb_rsp_valid(kb_rsp_valid), .kb_rsp_ready(kb_rsp_ready)
	);

	function automatic icb_pkg::icb_cmd_t make_cmd(input icb_pkg::icb_op_e op, input int lb,
			input int row, input cbuf_pkg::word_t data, input cbuf_pkg::mask_t mask);
		icb_pkg::icb_cmd_t c;
		c.addr = 32'((lb * cbuf_pkg::BANK_DEPTH + row) * cbuf_pkg::WORD_BYTES);
		c.op = op;
		c.wdata = data;
		c.wmask = mask;
		return c;
	endfunction

	// every 16-bit lane tied to the full word index
	function automatic cbuf_pkg::word_t fill_word(input int idx);
		logic [15:0] a;
		a = 16'(idx);
		return {a ^ 16'hA5C3, a * 16'd7 + 16'd3, ~a, a};
	endfunction

	function automatic cbuf_pkg::word_t rand_word();
		return {$urandom, $urandom};
	endfunction

	function automatic icb_pkg::icb_cmd_t rand_cmd();
		icb_pkg::icb_op_e op;
		op = ($urandom_range(0, 1) == 1) ? icb_pkg::ICB_READ : icb_pkg::ICB_WRITE;
		// logical bank spans the whole pool, so some land out of region
		return make_cmd(op, $urandom_range(0, cbuf_pkg::BANK_N - 1),
			$urandom_range(0, cbuf_pkg::BANK_DEPTH - 1), rand_word(), cbuf_pkg::mask_t'($urandom));
	endfunction

	function automatic bit go_now(input int pct);
		return !bp_mode || ($urandom_range(0, 99) < pct);
	endfunction

	function automatic bit all_idle();
		return fm_q.size() == 0 && kb_q.size() == 0 && fm_exp.size() == 0 &&
			kb_exp.size() == 0 && !fm_cmd_valid && !kb_cmd_valid;
	endfunction

	// byte model of the pool, mapping taken straight from the address rules
	task automatic apply_model(input bit kb, input icb_pkg::icb_cmd_t c,
			output icb_pkg::icb_rsp_t r);
		int widx;
		int lb;
		int row;
		int limit;
		int base;
		widx = int'(c.addr / cbuf_pkg::WORD_BYTES);
		lb = widx / cbuf_pkg::BANK_DEPTH;
		row = widx % cbuf_pkg::BANK_DEPTH;
		limit = kb ? cbuf_pkg::BANK_N - int'(fmbufbankn) : int'(fmbufbankn);
		base = ((kb ? int'(fmbufbankn) + lb : lb) * cbuf_pkg::BANK_DEPTH + row)
			* cbuf_pkg::WORD_BYTES;
		r.err = 1'b0;
		r.rdata = '0;
		if (lb >= limit) begin
			r.err = 1'b1;
		end else begin
			for (int i = 0; i < cbuf_pkg::WORD_BYTES; i++) begin
				if (c.op == icb_pkg::ICB_READ)
					r.rdata[i*8 +: 8] = ref_bytes[base + i];
				else if (c.wmask[i])
					ref_bytes[base + i] = c.wdata[i*8 +: 8];
			end
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_cnt++;
		assert (got == exp) else begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_rsp(input bit kb, input icb_pkg::icb_rsp_t got);
		icb_pkg::icb_rsp_t exp;
		string pname;
		int owed;
		pname = kb ? "kb" : "fm";
		owed = kb ? kb_exp.size() : fm_exp.size();
		check_cnt++;
		assert (owed > 0) else begin
			$display("%s port gave a response with no command outstanding", pname);
			err_cnt++;
		end
		if (owed > 0) begin
			if (kb)
				exp = kb_exp.pop_front();
			else
				exp = fm_exp.pop_front();
			check_bit({pname, "_rsp.err"}, got.err, exp.err);
			check_cnt++;
			assert (got.rdata == exp.rdata) else begin
				$display("Mismatch %s_rsp.rdata: got %h expected %h", pname, got.rdata, exp.rdata);
				err_cnt++;
			end
		end
	endtask

	task automatic send(input bit kb, input icb_pkg::icb_cmd_t c);
		if (kb)
			kb_q.push_back(c);
		else
			fm_q.push_back(c);
	endtask

	task automatic wait_idle();
		@(posedge aclk);
		while (!all_idle())
			@(posedge aclk);
	endtask

	// only called with both ports drained
	task automatic set_split(input int n);
		@(posedge aclk);
		#(DRIVE_DLY);
		fmbufbankn = cbuf_pkg::bank_cnt_t'(n);
		@(posedge aclk);
	endtask

	task automatic finish_test(input string name);
		int errs;
		wait_idle();
		errs = err_cnt - test_err0;
		test_cnt++;
		if (errs == 0)
			$display("test %0d %s: passed", test_cnt, name);
		else
			$display("test %0d %s: %0d errors", test_cnt, name, errs);
		test_err0 = err_cnt;
	endtask

	always @(posedge aclk)
		cycle <= cycle + 1;

	// drivers, a fixed delay after the edge
	always @(posedge aclk) begin
		#(DRIVE_DLY);
		if (!fm_cmd_valid || fm_fired) begin
			if (fm_q.size() > 0 && go_now(CMD_RATE)) begin
				fm_cmd = fm_q[0];
				fm_cmd_valid = 1'b1;
			end else begin
				fm_cmd_valid = 1'b0;
			end
		end
		if (!kb_cmd_valid || kb_fired) begin
			if (kb_q.size() > 0 && go_now(CMD_RATE)) begin
				kb_cmd = kb_q[0];
				kb_cmd_valid = 1'b1;
			end else begin
				kb_cmd_valid = 1'b0;
			end
		end
		fm_rsp_ready = go_now(RSP_RATE);
		kb_rsp_ready = go_now(RSP_RATE);
	end

	// mid-cycle: handshakes seen here transfer on the next rising edge
	always @(negedge aclk) begin
		fm_fired = 1'b0;
		kb_fired = 1'b0;
		if (rst_n) begin
			if (fm_rsp_valid && fm_rsp_ready) begin
				check_rsp(1'b0, fm_rsp);
				fm_rsp_cyc = cycle;
			end
			if (kb_rsp_valid && kb_rsp_ready)
				check_rsp(1'b1, kb_rsp);
			if (fm_cmd_valid && fm_cmd_ready) begin
				apply_model(1'b0, fm_cmd, model_rsp);
				fm_exp.push_back(model_rsp);
				fm_q.delete(0);
				fm_fired = 1'b1;
				fm_cmd_cyc = cycle;
			end
			if (kb_cmd_valid && kb_cmd_ready) begin
				apply_model(1'b1, kb_cmd, model_rsp);
				kb_exp.push_back(model_rsp);
				kb_q.delete(0);
				kb_fired = 1'b1;
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles with traffic still pending", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		fmbufbankn = cbuf_pkg::bank_cnt_t'(cbuf_pkg::BANK_N);
		fm_cmd = '0;
		fm_cmd_valid = 1'b0;
		fm_rsp_ready = 1'b1;
		kb_cmd = '0;
		kb_cmd_valid = 1'b0;
		kb_rsp_ready = 1'b1;
		bp_mode = 1'b0;
		fm_fired = 1'b0;
		kb_fired = 1'b0;
		void'($urandom(SEED));

		// 1: reset state, preload the whole pool through fm, then one timed read
		repeat (2) @(negedge aclk);
		check_bit("fm_rsp_valid", fm_rsp_valid, 1'b0);
		check_bit("kb_rsp_valid", kb_rsp_valid, 1'b0);
		@(posedge rst_n);
		@(negedge aclk);
		check_bit("fm_cmd_ready", fm_cmd_ready, 1'b1);
		check_bit("kb_cmd_ready", kb_cmd_ready, 1'b1);
		check_bit("fm_rsp_valid", fm_rsp_valid, 1'b0);
		check_bit("kb_rsp_valid", kb_rsp_valid, 1'b0);
		@(posedge aclk);
		for (int i = 0; i < FILL_N; i++)
			send(1'b0, make_cmd(icb_pkg::ICB_WRITE, i / cbuf_pkg::BANK_DEPTH,
				i % cbuf_pkg::BANK_DEPTH, fill_word(i), '1));
		wait_idle();
		send(1'b0, make_cmd(icb_pkg::ICB_READ, 5, 17, '0, '0));
		wait_idle();
		check_cnt++;
		assert (fm_rsp_cyc - fm_cmd_cyc == 3) else begin
			$display("fm read answered %0d cycles after its command, 3 expected",
				fm_rsp_cyc - fm_cmd_cyc);
			err_cnt++;
		end
		finish_test("reset, preload and read latency");

		// 2: masked writes then reads on the fm port
		set_split(4);
		for (int i = 0; i < PAIR_N; i++) begin
			pair_lb[i] = $urandom_range(0, 3);
			pair_row[i] = $urandom_range(0, cbuf_pkg::BANK_DEPTH - 1);
			send(1'b0, make_cmd(icb_pkg::ICB_WRITE, pair_lb[i], pair_row[i], rand_word(),
				cbuf_pkg::mask_t'($urandom)));
		end
		for (int i = 0; i < PAIR_N; i++)
			send(1'b0, make_cmd(icb_pkg::ICB_READ, pair_lb[i], pair_row[i], '0, '0));
		finish_test("fm masked writes");

		// 3: same logical addresses on kb, fm data must survive
		for (int i = 0; i < PAIR_N; i++)
			send(1'b1, make_cmd(icb_pkg::ICB_WRITE, pair_lb[i], pair_row[i], rand_word(),
				cbuf_pkg::mask_t'($urandom)));
		for (int i = 0; i < PAIR_N; i++) begin
			send(1'b1, make_cmd(icb_pkg::ICB_READ, pair_lb[i], pair_row[i], '0, '0));
			send(1'b0, make_cmd(icb_pkg::ICB_READ, pair_lb[i], pair_row[i], '0, '0));
		end
		finish_test("kb region offset");

		// 4: out of region on both ports, the kb write would alias fm bank 0
		send(1'b0, make_cmd(icb_pkg::ICB_WRITE, 4, 33, rand_word(), '1));
		send(1'b1, make_cmd(icb_pkg::ICB_WRITE, 4, 33, rand_word(), '1));
		send(1'b1, make_cmd(icb_pkg::ICB_READ, 5, 2, '0, '0));
		send(1'b1, make_cmd(icb_pkg::ICB_READ, 0, 33, '0, '0));
		send(1'b0, make_cmd(icb_pkg::ICB_READ, 0, 33, '0, '0));
		finish_test("bound protection");

		// 5: written as fm banks 2 and 3, read back as kb banks 0 and 1
		for (int i = 0; i < SPLIT_N; i++)
			send(1'b0, make_cmd(icb_pkg::ICB_WRITE, 2 + i % 2, i * 9, rand_word(), '1));
		wait_idle();
		set_split(2);
		for (int i = 0; i < SPLIT_N; i++)
			send(1'b1, make_cmd(icb_pkg::ICB_READ, i % 2, i * 9, '0, '0));
		finish_test("run-time split");

		// 6: random traffic on both ports with random stalls
		set_split($urandom_range(2, 6));
		bp_mode = 1'b1;
		for (int i = 0; i < RAND_N; i++) begin
			send(1'b0, rand_cmd());
			send(1'b1, rand_cmd());
		end
		wait_idle();
		bp_mode = 1'b0;
		finish_test("random back-pressure");

		$display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== conv_buffer.f ====
cbuf_pkg.sv
icb_pkg.sv
icb_reg_slice.sv
cbuf_port_access.sv
cbuf_bank_array.sv
conv_buffer.sv
tb_clk_gen.sv
tb_conv_buffer.sv

// ==== Makefile ====
# Verilator flow for the convolution buffer

LOG := sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert -j 0 --top-module tb_conv_buffer -f conv_buffer.f
	./obj_dir/Vtb_conv_buffer | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

lint:
	verilator --lint-only --timing --top-module conv_buffer -f conv_buffer.f

clean:
	rm -rf obj_dir $(LOG)
